// File: Makefile
VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: logic/lsu_axi_read.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_axi_read (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       rd_start,
    input  wire [`LSU_ADDR_W-1:0]     bus_addr,
    // read address channel
    output logic                      arvalid,
    input  wire                       arready,
    output logic [`LSU_ADDR_W-1:0]    araddr,
    // read data channel
    input  wire                       rvalid,
    output logic                      rready,
    input  wire [`LSU_DATA_W-1:0]     rdata,
    input  wire lsu_pkg::axi_resp_e   rresp,
    // result
    output logic                      rd_done,
    output logic [`LSU_DATA_W-1:0]    rd_data,
    output lsu_pkg::axi_resp_e        rd_resp
);
    lsu_pkg::rd_state_e state;

    // address is held by the control block for the whole beat
    assign araddr  = bus_addr;
    assign arvalid = (state == lsu_pkg::RD_ADDR);
    assign rready  = (state == lsu_pkg::RD_DATA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= lsu_pkg::RD_IDLE;
            rd_done <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                lsu_pkg::RD_IDLE: if (rd_start) state <= lsu_pkg::RD_ADDR;
                lsu_pkg::RD_ADDR: if (arready) state <= lsu_pkg::RD_DATA;
                lsu_pkg::RD_DATA: begin
                    if (rvalid) begin
                        state   <= lsu_pkg::RD_IDLE;
                        rd_done <= 1'b1;
                    end
                end
                default: state <= lsu_pkg::RD_IDLE;
            endcase
        end
    end

    // capture the beat at the data handshake
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            rd_data <= rdata;
            rd_resp <= rresp;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_axi_write.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_axi_write (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       wr_start,
    input  wire [`LSU_ADDR_W-1:0]     bus_addr,
    input  wire [`LSU_DATA_W-1:0]     bus_wdata,
    input  wire [`LSU_DATA_W/8-1:0]   bus_wstrb,
    // write address channel
    output logic                      awvalid,
    input  wire                       awready,
    output logic [`LSU_ADDR_W-1:0]    awaddr,
    // write data channel
    output logic                      wvalid,
    input  wire                       wready,
    output logic [`LSU_DATA_W-1:0]    wdata,
    output logic [`LSU_DATA_W/8-1:0]  wstrb,
    // write response channel
    input  wire                       bvalid,
    output logic                      bready,
    input  wire lsu_pkg::axi_resp_e   bresp,
    // result
    output logic                      wr_done,
    output lsu_pkg::axi_resp_e        wr_resp
);
    lsu_pkg::wr_state_e state;

    // per-channel completion, the slave may take aw and w in any order
    logic aw_sent;
    logic w_sent;
    logic aw_fin;
    logic w_fin;

    assign awaddr  = bus_addr;
    assign wdata   = bus_wdata;
    assign wstrb   = bus_wstrb;

    assign awvalid = (state == lsu_pkg::WR_SEND) && !aw_sent;
    assign wvalid  = (state == lsu_pkg::WR_SEND) && !w_sent;
    assign bready  = (state == lsu_pkg::WR_RESP);

    assign aw_fin  = aw_sent || (awvalid && awready);
    assign w_fin   = w_sent || (wvalid && wready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= lsu_pkg::WR_IDLE;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                lsu_pkg::WR_IDLE: begin
                    if (wr_start) begin
                        state <= lsu_pkg::WR_SEND;
                    end
                end
                lsu_pkg::WR_SEND: begin
                    aw_sent <= aw_fin;
                    w_sent  <= w_fin;
                    if (aw_fin && w_fin) begin
                        state   <= lsu_pkg::WR_RESP;
                        aw_sent <= 1'b0;
                        w_sent  <= 1'b0;
                    end
                end
                lsu_pkg::WR_RESP: begin
                    if (bvalid) begin
                        state   <= lsu_pkg::WR_IDLE;
                        wr_done <= 1'b1;
                    end
                end
                default: state <= lsu_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bvalid && bready) begin
            wr_resp <= bresp;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    // execute side
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire lsu_pkg::mem_op_e     in_op,
    input  wire [`LSU_ADDR_W-1:0]     in_addr,
    input  wire [`LSU_DATA_W-1:0]     in_wdata,
    // writeback side
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic [`LSU_DATA_W-1:0]    out_data,
    output logic                      out_fault,
    // engine side
    output logic                      rd_start,
    output logic                      wr_start,
    output logic [`LSU_ADDR_W-1:0]    bus_addr,
    output logic [`LSU_DATA_W-1:0]    bus_wdata,
    output logic [`LSU_DATA_W/8-1:0]  bus_wstrb,
    input  wire                       rd_done,
    input  wire [`LSU_DATA_W-1:0]     rd_data,
    input  wire lsu_pkg::axi_resp_e   rd_resp,
    input  wire                       wr_done,
    input  wire lsu_pkg::axi_resp_e   wr_resp
);
    localparam int STRB_W = `LSU_DATA_W / 8;

    lsu_pkg::ctrl_state_e   state;
    lsu_pkg::mem_op_e       req_op;
    logic [1:0]             req_off;

    logic                   accept;
    logic [1:0]             in_off;
    logic [1:0]             size;
    logic                   is_load;
    logic                   is_store;
    logic                   misaligned;
    logic                   bypass;
    logic [STRB_W-1:0]      strb_base;
    logic [`LSU_DATA_W-1:0] rd_shift;
    logic [`LSU_DATA_W-1:0] load_data;

    assign in_ready  = (state == lsu_pkg::CTRL_IDLE);
    assign out_valid = (state == lsu_pkg::CTRL_DONE);
    assign accept    = in_valid && in_ready;
    assign in_off    = in_addr[1:0];

    // ======================================================================
    // request decode
    // ======================================================================

    // size: 0 byte, 1 half, 2 word
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = 2'd2;
        case (in_op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU: begin
                is_load = 1'b1;
                size    = 2'd0;
            end
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU: begin
                is_load = 1'b1;
                size    = 2'd1;
            end
            lsu_pkg::OP_LW: is_load = 1'b1;
            lsu_pkg::OP_SB: begin
                is_store = 1'b1;
                size     = 2'd0;
            end
            lsu_pkg::OP_SH: begin
                is_store = 1'b1;
                size     = 2'd1;
            end
            lsu_pkg::OP_SW: is_store = 1'b1;
            default: ;
        endcase
    end

    assign misaligned = (is_load || is_store) &&
                        ((size == 2'd1 && in_off[0]) || (size == 2'd2 && in_off != 2'd0));
    // pass-through and faulting requests never reach the bus
    assign bypass = !(is_load || is_store) || (misaligned && `LSU_MISALIGN_FAULT);

    always_comb begin
        case (size)
            2'd0:    strb_base = STRB_W'(1);
            2'd1:    strb_base = STRB_W'(3);
            default: strb_base = '1;
        endcase
    end

    // ======================================================================
    // load data shaping
    // ======================================================================

    assign rd_shift = rd_data >> {req_off, 3'b000};

    always_comb begin
        case (req_op)
            lsu_pkg::OP_LB:  load_data = {{(`LSU_DATA_W-8){rd_shift[7]}}, rd_shift[7:0]};
            lsu_pkg::OP_LBU: load_data = {{(`LSU_DATA_W-8){1'b0}}, rd_shift[7:0]};
            lsu_pkg::OP_LH:  load_data = {{(`LSU_DATA_W-16){rd_shift[15]}}, rd_shift[15:0]};
            lsu_pkg::OP_LHU: load_data = {{(`LSU_DATA_W-16){1'b0}}, rd_shift[15:0]};
            default:         load_data = rd_shift;
        endcase
    end

    // ======================================================================
    // control FSM
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= lsu_pkg::CTRL_IDLE;
            rd_start  <= 1'b0;
            wr_start  <= 1'b0;
            out_fault <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                lsu_pkg::CTRL_IDLE: begin
                    if (accept) begin
                        if (bypass) begin
                            state     <= lsu_pkg::CTRL_DONE;
                            out_fault <= misaligned;
                        end else begin
                            state    <= lsu_pkg::CTRL_WAIT;
                            rd_start <= is_load;
                            wr_start <= is_store;
                        end
                    end
                end
                lsu_pkg::CTRL_WAIT: begin
                    if (rd_done) begin
                        state     <= lsu_pkg::CTRL_DONE;
                        out_fault <= (rd_resp != lsu_pkg::RESP_OKAY);
                    end else if (wr_done) begin
                        state     <= lsu_pkg::CTRL_DONE;
                        out_fault <= (wr_resp != lsu_pkg::RESP_OKAY);
                    end
                end
                lsu_pkg::CTRL_DONE: begin
                    if (out_ready) begin
                        state <= lsu_pkg::CTRL_IDLE;
                    end
                end
                default: state <= lsu_pkg::CTRL_IDLE;
            endcase
        end
    end

    // request payload and result word
    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= in_op;
            req_off   <= in_off;
            bus_addr  <= {in_addr[`LSU_ADDR_W-1:2], 2'b00};
            bus_wdata <= in_wdata << {in_off, 3'b000};
            bus_wstrb <= strb_base << in_off;
            out_data  <= (is_load || is_store) ? '0 : `LSU_DATA_W'(in_addr);
        end else if (state == lsu_pkg::CTRL_WAIT) begin
            if (rd_done) begin
                out_data <= load_data;
            end else if (wr_done) begin
                out_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // memory operations issued by execute
    typedef enum logic [3:0] {
        OP_LB   = 4'd0,
        OP_LH   = 4'd1,
        OP_LW   = 4'd2,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd8,
        OP_SH   = 4'd9,
        OP_SW   = 4'd10,
        OP_PASS = 4'd15
    } mem_op_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_WAIT, CTRL_DONE} ctrl_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_e;

endpackage

`default_nettype wire

// File: logic/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ======================================================================
// bus geometry
// ======================================================================

// byte address width
`define LSU_ADDR_W 32

// one data beat, one register word
`define LSU_DATA_W 32

// misaligned half/word access policy
// 1: fault at once, no bus access
// 0: access goes out on the containing word with a truncated strobe
`define LSU_MISALIGN_FAULT 1'b1

`endif

// File: logic/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_top (
    input  wire                       clk,
    input  wire                       rst,
    // execute stage
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire lsu_pkg::mem_op_e     in_op,
    input  wire [`LSU_ADDR_W-1:0]     in_addr,
    input  wire [`LSU_DATA_W-1:0]     in_wdata,
    // writeback stage
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic [`LSU_DATA_W-1:0]    out_data,
    output logic                      out_fault,
    // AXI write
    output logic                      awvalid,
    input  wire                       awready,
    output logic [`LSU_ADDR_W-1:0]    awaddr,
    output logic                      wvalid,
    input  wire                       wready,
    output logic [`LSU_DATA_W-1:0]    wdata,
    output logic [`LSU_DATA_W/8-1:0]  wstrb,
    input  wire                       bvalid,
    output logic                      bready,
    input  wire lsu_pkg::axi_resp_e   bresp,
    // AXI read
    output logic                      arvalid,
    input  wire                       arready,
    output logic [`LSU_ADDR_W-1:0]    araddr,
    input  wire                       rvalid,
    output logic                      rready,
    input  wire [`LSU_DATA_W-1:0]     rdata,
    input  wire lsu_pkg::axi_resp_e   rresp
);
    logic                      rd_start;
    logic                      wr_start;
    logic [`LSU_ADDR_W-1:0]    bus_addr;
    logic [`LSU_DATA_W-1:0]    bus_wdata;
    logic [`LSU_DATA_W/8-1:0]  bus_wstrb;
    logic                      rd_done;
    logic [`LSU_DATA_W-1:0]    rd_data;
    lsu_pkg::axi_resp_e        rd_resp;
    logic                      wr_done;
    lsu_pkg::axi_resp_e        wr_resp;

    lsu_ctrl u_ctrl (
        .clk, .rst,
        .in_valid, .in_ready, .in_op, .in_addr, .in_wdata,
        .out_valid, .out_ready, .out_data, .out_fault,
        .rd_start, .wr_start, .bus_addr, .bus_wdata, .bus_wstrb,
        .rd_done, .rd_data, .rd_resp,
        .wr_done, .wr_resp
    );

    lsu_axi_read u_rd (
        .clk, .rst,
        .rd_start, .bus_addr,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .rd_done, .rd_data, .rd_resp
    );

    lsu_axi_write u_wr (
        .clk, .rst,
        .wr_start, .bus_addr, .bus_wdata, .bus_wstrb,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .wr_done, .wr_resp
    );

endmodule

`default_nettype wire

// File: tb/lsu_assertions.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_assertions (
    input wire                   clk,
    input wire                   rst,
    input wire                   awvalid,
    input wire                   awready,
    input wire                   wvalid,
    input wire                   wready,
    input wire                   arvalid,
    input wire                   arready,
    input wire                   in_ready,
    input wire                   out_valid,
    input wire                   out_ready,
    input wire [`LSU_DATA_W-1:0] out_data
);
    // ======================================================================
    // AXI valid must wait for ready
    // ======================================================================

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // only one request in flight
    no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
        else $error("read and write address issued together");

    // ======================================================================
    // stage handshake
    // ======================================================================

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("result changed before writeback took it");

    // the next request may enter right after writeback takes the result
    in_ready_return: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |=> in_ready && !out_valid)
        else $error("in_ready did not return after the result was taken");

endmodule

bind lsu_top lsu_assertions u_assert (
    .clk, .rst,
    .awvalid, .awready, .wvalid, .wready, .arvalid, .arready,
    .in_ready, .out_valid, .out_ready, .out_data
);

`default_nettype wire

// File: tb/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_tb;
    localparam logic [31:0] SEED       = 32'h86378351;
    localparam int          MEM_WORDS  = 256;
    localparam int          REQ_N      = 400;
    localparam logic [3:0]  ERR_REGION = 4'hF;
    localparam int          CLK_NS     = 4;

    integer seed = SEED;
    logic   clk  = 1'b0;
    logic   rst;

    logic                     in_valid, in_ready, out_valid, out_ready, out_fault;
    lsu_pkg::mem_op_e         in_op;
    logic [`LSU_ADDR_W-1:0]   in_addr, awaddr, araddr;
    logic [`LSU_DATA_W-1:0]   in_wdata, out_data, wdata;
    logic [`LSU_DATA_W/8-1:0] wstrb;
    logic                     awvalid, wvalid, bready, arvalid, rready;
    logic                     awready = 1'b0;
    logic                     wready  = 1'b0;
    logic                     bvalid  = 1'b0;
    logic                     arready = 1'b0;
    logic                     rvalid  = 1'b0;
    logic [`LSU_DATA_W-1:0]   rdata   = '0;
    lsu_pkg::axi_resp_e       bresp   = lsu_pkg::RESP_OKAY;
    lsu_pkg::axi_resp_e       rresp   = lsu_pkg::RESP_OKAY;

    // slave memory and the model's shadow of it
    logic [31:0] mem    [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];

    logic [31:0] rnd_w, rnd_r, rnd_s, aw_addr_q, w_data_q, ar_addr_q;
    logic [3:0]  w_strb_q;
    logic [1:0]  b_wait, r_wait;
    logic        aw_take, w_take, b_take, aw_got, w_got, b_pend;
    logic        ar_take, r_take, r_pend;
    int          done_cnt = 0;

    always #(CLK_NS / 2) clk = ~clk;

    lsu_top DUT (.*);

    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9E3779B1) ^ SEED;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // expected result per request, stores update the shadow in order
    task automatic predict(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wd, output logic [31:0] data,
                           output logic fault);
        int          nbytes;
        logic        load;
        logic [7:0]  idx;
        logic [1:0]  off;
        logic [31:0] word;
        idx   = addr[9:2];
        off   = addr[1:0];
        data  = '0;
        fault = 1'b0;
        load  = op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
                           lsu_pkg::OP_LBU, lsu_pkg::OP_LHU};
        case (op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: nbytes = 1;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: nbytes = 2;
            lsu_pkg::OP_PASS: nbytes = 0;
            default: nbytes = 4;
        endcase
        if (nbytes == 0) begin
            data = addr;
        end else if (off % nbytes != 0 || addr[31:28] == ERR_REGION) begin
            // the slave returns zero data with its error response
            fault = 1'b1;
        end else if (load) begin
            word = shadow[idx] >> (8 * off);
            case (op)
                lsu_pkg::OP_LB:  data = {{24{word[7]}}, word[7:0]};
                lsu_pkg::OP_LBU: data = {24'h0, word[7:0]};
                lsu_pkg::OP_LH:  data = {{16{word[15]}}, word[15:0]};
                lsu_pkg::OP_LHU: data = {16'h0, word[15:0]};
                default:         data = word;
            endcase
        end else begin
            for (int b = 0; b < nbytes; b++) begin
                shadow[idx][8*(off+b) +: 8] = wd[8*b +: 8];
            end
        end
    endtask

    // ======================================================================
    // AXI slave, write side
    // ======================================================================

    // handshakes are predicted one step ahead and applied after the edge
    always @(posedge clk) begin
        #1;
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
            {awready, wready, bvalid, aw_take, w_take, b_take} = '0;
            {aw_got, w_got, b_pend} = '0;
        end else begin
            rnd_w = $random(seed);
            if (b_take) bvalid = 1'b0;
            if (aw_take) aw_got = 1'b1;
            if (w_take) w_got = 1'b1;
            if (aw_got && w_got) begin
                bresp = lsu_pkg::RESP_SLVERR;
                if (aw_addr_q[31:28] != ERR_REGION) begin
                    bresp = lsu_pkg::RESP_OKAY;
                    for (int j = 0; j < 4; j++) begin
                        if (w_strb_q[j]) mem[aw_addr_q[9:2]][8*j +: 8] = w_data_q[8*j +: 8];
                    end
                end
                {aw_got, w_got} = 2'b00;
                b_pend = 1'b1;
                b_wait = rnd_w[3:2];
            end
            if (b_pend) begin
                if (b_wait == 2'd0) begin
                    bvalid = 1'b1;
                    b_pend = 1'b0;
                end else begin
                    b_wait = b_wait - 2'd1;
                end
            end
            awready = !aw_got && rnd_w[0];
            wready  = !w_got && rnd_w[1];
            aw_take = awvalid && awready;
            w_take  = wvalid && wready;
            b_take  = bvalid && bready;
            if (aw_take) aw_addr_q = awaddr;
            if (w_take) begin
                w_data_q = wdata;
                w_strb_q = wstrb;
            end
        end
    end

    // ======================================================================
    // AXI slave, read side
    // ======================================================================

    always @(posedge clk) begin
        #1;
        if (rst) begin
            {arready, rvalid, ar_take, r_take, r_pend} = '0;
        end else begin
            rnd_r = $random(seed);
            if (r_take) rvalid = 1'b0;
            if (ar_take) begin
                r_pend = 1'b1;
                r_wait = rnd_r[3:2];
                rresp  = lsu_pkg::RESP_OKAY;
                rdata  = mem[ar_addr_q[9:2]];
                if (ar_addr_q[31:28] == ERR_REGION) begin
                    rresp = lsu_pkg::RESP_SLVERR;
                    rdata = '0;
                end
            end
            if (r_pend) begin
                if (r_wait == 2'd0) begin
                    rvalid = 1'b1;
                    r_pend = 1'b0;
                end else begin
                    r_wait = r_wait - 2'd1;
                end
            end
            arready = !r_pend && !rvalid && rnd_r[0];
            ar_take = arvalid && arready;
            r_take  = rvalid && rready;
            if (ar_take) ar_addr_q = araddr;
        end
    end

    // ======================================================================
    // requests and checks
    // ======================================================================

    initial begin : stimulus
        lsu_pkg::mem_op_e ops [9];
        lsu_pkg::mem_op_e op;
        logic [31:0]      addr, wd, exp_data;
        logic [1:0]       off;
        logic             exp_fault, taken;
        ops = '{lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW, lsu_pkg::OP_LBU,
                lsu_pkg::OP_LHU, lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW,
                lsu_pkg::OP_PASS};
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_op     = lsu_pkg::OP_PASS;
        in_addr   = '0;
        in_wdata  = '0;
        out_ready = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) shadow[i] = fill_word(i);
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        for (int n = 0; n < REQ_N; n++) begin
            rnd_s = $random(seed);
            op    = ops[rnd_s[31:24] % 9];
            off   = rnd_s[8] ? 2'b00 : rnd_s[1:0];
            // 16 words shared by all regions so later loads see earlier stores
            addr  = {(rnd_s[23:21] == 3'd0) ? ERR_REGION : 4'h0, 22'h0, rnd_s[7:4], off};
            if (op == lsu_pkg::OP_PASS) addr = $random(seed);
            wd = $random(seed);
            predict(op, addr, wd, exp_data, exp_fault);
            repeat (int'(rnd_s[10:9])) begin
                @(posedge clk);
                #1;
            end
            check_value("out_valid", 32'(out_valid), 32'd0);
            in_valid = 1'b1;
            in_op    = op;
            in_addr  = addr;
            in_wdata = wd;
            while (!in_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            taken    = 1'b0;
            while (!taken) begin
                rnd_s     = $random(seed);
                out_ready = rnd_s[0] | rnd_s[1];
                if (out_valid && out_ready) begin
                    check_value("out_data", out_data, exp_data);
                    check_value("out_fault", 32'(out_fault), 32'(exp_fault));
                    taken = 1'b1;
                end
                @(posedge clk);
                #1;
            end
            out_ready = 1'b0;
            done_cnt++;
        end
        $display("RESULT: PASS");
        $finish;
    end

    // bus operations take well under 40 cycles even with every stall
    initial begin : watchdog
        #(REQ_N * 40 * CLK_NS);
        $display("run hung: only %0d of %0d requests completed", done_cnt, REQ_N);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_ctrl.sv
logic/lsu_axi_read.sv
logic/lsu_axi_write.sv
logic/lsu_top.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv
